//--- hw/audio_pkg.sv
package audio_pkg;

    // ----------------------------------------------------------
    // Sample types

    typedef logic signed [23:0] mic_t;      // INMP441 sample
    typedef logic signed [15:0] sound_t;    // DAC sample

    // ----------------------------------------------------------
    // I2S framing

    localparam int i2s_slot_bits  = 32;                 // Bit clocks per channel
    localparam int i2s_frame_bits = 2 * i2s_slot_bits;  // Left plus right slot

    // Both sides run the same free-running frame:
    // ws/lrclk low for the left slot, high for the right one,
    // data MSB first one bit clock after the ws edge

endpackage

//--- hw/board_pkg.sv
`include "board_cfg.svh"

package board_pkg;

    // ----------------------------------------------------------
    // Display, key and LED types

    typedef logic [7:0]              seg_t;     // abcdefgh, a in bit 7
    typedef logic [`TM_DIGITS - 1:0] digit_t;   // One hot digit select
    typedef logic [`TM_DIGITS - 1:0] key_t;     // Merged key mask
    typedef logic [`W_LED - 1:0]     led_t;     // LED mask

    // ----------------------------------------------------------
    // TM1638 serial link

    localparam logic [7:0] tm_cmd_write = 8'h40;    // Data write, auto increment
    localparam logic [7:0] tm_cmd_addr  = 8'hC0;    // Start at address 0
    localparam logic [7:0] tm_cmd_on    = 8'h8F;    // Display on, full brightness
    localparam logic [7:0] tm_cmd_read  = 8'h42;    // Key scan read

    localparam int tm_write_bytes = 2 * `TM_DIGITS; // Segment and LED bytes per frame
    localparam int tm_read_bytes  = 4;              // Key bytes per frame

endpackage

//--- hw/board_top.sv
`include "board_cfg.svh"

module board_top
(
    input  logic                clk,
    input  logic                rst,

    input  logic [`W_KEY - 1:0] key,        // Onboard, active low
    input  logic [`W_SW  - 1:0] sw,
    input  logic                mic_sd,

    output logic [`W_LED - 1:0] led,        // Onboard LEDs

    output logic                tm_stb,
    output logic                tm_clk,
    inout  wire                 tm_dio,

    output logic                mic_lr,
    output logic                mic_ws,
    output logic                mic_sck,

    output logic                i2s_mclk,
    output logic                i2s_bclk,
    output logic                i2s_lrclk,
    output logic                i2s_sdata
);

    import board_pkg::*;
    import audio_pkg::*;

    key_t   lab_keys;   // Daughterboard keys with onboard keys ORed in
    mic_t   mic;
    sound_t sound;

    display_if disp ();

    // ----------------------------------------------------------
    // Key merge and onboard outputs

    always_comb
    begin
        lab_keys                  = disp.keys;
        lab_keys [`W_KEY - 1:0]  |= ~ key;    // Pressed key reads 0
    end

    assign led    = disp.led;               // Same pattern as the board LEDs
    assign mic_lr = 1'b0;                   // Mic answers in the left slot

    // ----------------------------------------------------------
    // Blocks

    lab_top i_lab_top
    (
        .clk   ( clk      ),
        .rst   ( rst      ),
        .keys  ( lab_keys ),
        .sw    ( sw       ),
        .mic   ( mic      ),
        .sound ( sound    ),
        .disp  ( disp     )
    );

    tm1638_ctrl i_tm1638
    (
        .clk      ( clk    ),
        .rst      ( rst    ),
        .disp     ( disp   ),
        .stb      ( tm_stb ),
        .sio_clk  ( tm_clk ),
        .sio_data ( tm_dio )
    );

    i2s_mic_rx i_mic
    (
        .clk   ( clk     ),
        .rst   ( rst     ),
        .sd    ( mic_sd  ),
        .sck   ( mic_sck ),
        .ws    ( mic_ws  ),
        .value ( mic     )
    );

    i2s_dac_tx i_dac
    (
        .clk     ( clk       ),
        .rst     ( rst       ),
        .data_in ( sound     ),
        .mclk    ( i2s_mclk  ),
        .bclk    ( i2s_bclk  ),
        .lrclk   ( i2s_lrclk ),
        .sdata   ( i2s_sdata )
    );

endmodule

//--- hw/display_if.sv
interface display_if;

    import board_pkg::*;

    seg_t   seg;        // Segments of the selected digit
    digit_t digit;      // Scan position
    led_t   led;        // LED pattern
    key_t   keys;       // Keys read from the board

    // Lab side produces the picture and consumes keys
    modport lab
    (
        output seg, digit, led,
        input  keys
    );

    // Board controller side
    modport ctrl
    (
        input  seg, digit, led,
        output keys
    );

endinterface

//--- hw/i2s_dac_tx.sv
`include "board_cfg.svh"

module i2s_dac_tx
(
    input  logic              clk,
    input  logic              rst,
    input  audio_pkg::sound_t data_in,
    output logic              mclk,
    output logic              bclk,
    output logic              lrclk,
    output logic              sdata
);

    import audio_pkg::*;

    localparam int div_w    = $clog2(`I2S_HALF_DIV);
    localparam int cnt_w    = $clog2(i2s_frame_bits);
    localparam int snd_bits = $bits(sound_t);

    logic [div_w - 1:0] div_cnt;
    logic [cnt_w - 1:0] bit_cnt;        // Bclk periods since lrclk fell
    logic [cnt_w - 1:0] nxt_cnt;
    logic [cnt_w - 2:0] slot_pos;       // Position in the slot after this edge
    logic               tick;
    logic               fall;           // Bclk about to go low
    sound_t             sample;         // Held for the right slot
    sound_t             shift;

    assign tick     = div_cnt == div_w'(`I2S_HALF_DIV - 1);
    assign fall     = tick && bclk;
    assign nxt_cnt  = bit_cnt + 1'b1;
    assign slot_pos = nxt_cnt [cnt_w - 2:0];
    assign lrclk    = bit_cnt [cnt_w - 1];      // Changes with the falling bclk

    // ----------------------------------------------------------
    // Clocks

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk    <= 1'b0;
            bclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end
        else
        begin
            mclk    <= ~ mclk;                  // Clk / 2
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                bclk <= ~ bclk;
            if (fall)
                bit_cnt <= nxt_cnt;
        end
    end

    // ----------------------------------------------------------
    // Serializer, data moves only while bclk is low

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample <= '0;
            shift  <= '0;
            sdata  <= 1'b0;
        end
        else if (fall)
        begin
            sdata <= 1'b0;                      // Padding after the sample
            if (nxt_cnt == '0)
                sample <= data_in;              // Frame start
            if (slot_pos == '0)
                shift <= (nxt_cnt == '0) ? data_in : sample;
            else if (slot_pos <= snd_bits)
            begin
                sdata <= shift [snd_bits - 1];  // MSB first
                shift <= shift << 1;
            end
        end
    end

endmodule

//--- hw/i2s_mic_rx.sv
`include "board_cfg.svh"

module i2s_mic_rx
(
    input  logic            clk,
    input  logic            rst,
    input  logic            sd,
    output logic            sck,
    output logic            ws,
    output audio_pkg::mic_t value
);

    import audio_pkg::*;

    localparam int div_w    = $clog2(`I2S_HALF_DIV);
    localparam int cnt_w    = $clog2(i2s_frame_bits);
    localparam int mic_bits = $bits(mic_t);

    logic [div_w - 1:0] div_cnt;
    logic [cnt_w - 1:0] bit_cnt;        // Sck periods since ws fell
    logic               tick;
    logic               in_left;        // Sample bits of the left slot
    mic_t               shift;

    assign tick    = div_cnt == div_w'(`I2S_HALF_DIV - 1);
    assign ws      = bit_cnt [cnt_w - 1];                   // High in the right slot
    assign in_left = bit_cnt >= 1 && bit_cnt <= mic_bits;   // One sck of delay

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            value   <= '0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (tick)
            begin
                sck <= ~ sck;
                if (sck)                                    // Falling edge
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == cnt_w'(i2s_slot_bits - 1))
                        value <= shift;                     // Ws rises
                end
            end
        end
    end

    // Mic drives on the falling edge, sample on the rising one
    always_ff @(posedge clk)
    begin
        if (tick && !sck && in_left)
            shift <= {shift [mic_bits - 2:0], sd};
    end

endmodule

//--- hw/lab_top.sv
`include "board_cfg.svh"

module lab_top
(
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::key_t     keys,
    input  logic [`W_SW - 1:0]  sw,
    input  audio_pkg::mic_t     mic,
    output audio_pkg::sound_t   sound,
    display_if.lab              disp
);

    import board_pkg::*;

    localparam int scan_w  = $clog2(`SCAN_DIV);
    localparam int digit_w = $clog2(`TM_DIGITS);

    logic [scan_w  - 1:0] scan_cnt;     // Time on the current digit
    logic [digit_w - 1:0] digit_idx;    // Digit being shown
    logic [3:0]           nibble;
    logic                 blank;

    // Hex digit to abcdefgh, segment on = 1
    function automatic seg_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0:    hex_to_seg = 8'b1111_1100;
            4'h1:    hex_to_seg = 8'b0110_0000;
            4'h2:    hex_to_seg = 8'b1101_1010;
            4'h3:    hex_to_seg = 8'b1111_0010;
            4'h4:    hex_to_seg = 8'b0110_0110;
            4'h5:    hex_to_seg = 8'b1011_0110;
            4'h6:    hex_to_seg = 8'b1011_1110;
            4'h7:    hex_to_seg = 8'b1110_0000;
            4'h8:    hex_to_seg = 8'b1111_1110;
            4'h9:    hex_to_seg = 8'b1111_0110;
            4'ha:    hex_to_seg = 8'b1110_1110;
            4'hb:    hex_to_seg = 8'b0011_1110;   // Lower case b
            4'hc:    hex_to_seg = 8'b1001_1100;
            4'hd:    hex_to_seg = 8'b0111_1010;   // Lower case d
            4'he:    hex_to_seg = 8'b1001_1110;
            default: hex_to_seg = 8'b1000_1110;
        endcase
    endfunction

    // ----------------------------------------------------------
    // Digit contents

    always_comb
    begin
        blank  = 1'b0;
        nibble = 4'h0;

        case (digit_idx)
            digit_w'(0): nibble = keys [3:0];   // Low key nibble
            digit_w'(1): nibble = keys [7:4];   // High key nibble
            digit_w'(2): nibble = 4'(sw);
            default:     blank  = 1'b1;         // Unused digits dark
        endcase
    end

    assign disp.seg   = blank ? '0 : hex_to_seg(nibble);
    assign disp.digit = digit_t'(1) << digit_idx;

    // ----------------------------------------------------------
    // Scan, LEDs and audio path

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
            disp.led  <= '0;
            sound     <= '0;
        end
        else
        begin
            if (scan_cnt == scan_w'(`SCAN_DIV - 1))
            begin
                scan_cnt  <= '0;
                digit_idx <= digit_idx + 1'b1;      // Wraps after the last digit
            end
            else
                scan_cnt  <= scan_cnt + 1'b1;

            disp.led <= led_t'(keys);                // Key mask mirror
            sound    <= sw [0] ? mic [$bits(mic) - 1 -: $bits(sound)] : '0;
        end
    end

endmodule

//--- hw/tm1638_ctrl.sv
`include "board_cfg.svh"

module tm1638_ctrl
(
    input  logic    clk,
    input  logic    rst,
    display_if.ctrl disp,
    output logic    stb,
    output logic    sio_clk,
    inout  wire     sio_data
);

    import board_pkg::*;

    typedef enum logic [1:0] { S_GAP, S_LOW, S_HIGH } state_t;

    localparam int div_w = $clog2(`TM_HALF_DIV);

    state_t             state;
    logic [div_w - 1:0] div_cnt;
    logic               tick;           // One serial half period
    logic               gap_cnt;        // Second half of the stb high gap
    logic [1:0]         grp;            // Write cmd, address and data, display on, read
    logic [4:0]         byte_idx;       // Byte inside the group
    logic [2:0]         bit_idx;
    logic               oe;             // We own dio
    logic [7:0]         tx_shift;
    logic [7:0]         rx_shift;
    seg_t               seg_mem [`TM_DIGITS];
    key_t               key_acc;        // Keys gathered over the read bytes
    key_t               key_merge;
    logic               load;
    logic [4:0]         load_idx;
    logic [4:0]         slot;           // Data byte after the address command
    logic [4:0]         last_idx;
    logic [7:0]         tx_byte;
    logic               reading;
    logic [1:0]         rd_byte;

    assign sio_data = oe ? tx_shift [0] : 1'bz;     // LSB first

    // ----------------------------------------------------------
    // Half period divider

    assign tick = div_cnt == div_w'(`TM_HALF_DIV - 1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end

    // Segment memory follows the scan of the lab logic
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `TM_DIGITS; i++)
            if (disp.digit [i])
                seg_mem [i] <= disp.seg;
    end

    // ----------------------------------------------------------
    // Byte selection

    assign load_idx = (state == S_GAP) ? 5'd0 : byte_idx + 5'd1;
    assign slot     = load_idx - 5'd1;
    assign reading  = (grp == 2'd3) && (byte_idx != 5'd0);
    assign rd_byte  = 2'(byte_idx - 5'd1);
    assign load     = tick && ((state == S_GAP && gap_cnt)
                      || (state == S_HIGH && bit_idx == 3'd7 && byte_idx != last_idx));

    always_comb
    begin
        case (grp)
            2'd1:    last_idx = 5'(tm_write_bytes);
            2'd3:    last_idx = 5'(tm_read_bytes);
            default: last_idx = 5'd0;               // Single command byte
        endcase

        case (grp)
            2'd0:    tx_byte = tm_cmd_write;
            2'd1:
                if (load_idx == 5'd0)
                    tx_byte = tm_cmd_addr;
                else if (slot [0])
                    tx_byte = {7'b0, disp.led [slot [3:1]]};  // Odd byte is an LED
                else
                    tx_byte = seg_mem [slot [3:1]];
            2'd2:    tx_byte = tm_cmd_on;
            default: tx_byte = (load_idx == 5'd0) ? tm_cmd_read : 8'h00;
        endcase
    end

    // Read byte b: bit 0 is key b, bit 4 is key b + 4
    always_comb
    begin
        key_merge                    = key_acc;
        key_merge [{1'b0, rd_byte}]  = rx_shift [0];
        key_merge [{1'b1, rd_byte}]  = rx_shift [4];
    end

    // ----------------------------------------------------------
    // Shifters

    always_ff @(posedge clk)
    begin
        if (load)
            tx_shift <= tx_byte;
        else if (tick && state == S_HIGH)
            tx_shift <= tx_shift >> 1;

        if (tick && state == S_LOW)
            rx_shift <= {sio_data, rx_shift [7:1]};  // Sampled as the clock rises
    end

    // ----------------------------------------------------------
    // Frame sequencer

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= S_GAP;
            gap_cnt   <= 1'b0;
            grp       <= 2'd0;
            byte_idx  <= '0;
            bit_idx   <= '0;
            stb       <= 1'b1;
            sio_clk   <= 1'b1;
            oe        <= 1'b0;
            key_acc   <= '0;
            disp.keys <= '0;
        end
        else if (tick)
        begin
            case (state)
                S_GAP:
                begin
                    gap_cnt <= ~ gap_cnt;
                    if (gap_cnt)                        // Gap over, open the group
                    begin
                        state    <= S_LOW;
                        stb      <= 1'b0;
                        sio_clk  <= 1'b0;
                        oe       <= 1'b1;
                        byte_idx <= '0;
                        bit_idx  <= '0;
                    end
                end

                S_LOW:
                begin
                    state   <= S_HIGH;
                    sio_clk <= 1'b1;
                end

                S_HIGH:
                begin
                    if (reading && bit_idx == 3'd7)
                        key_acc <= key_merge;

                    if (bit_idx != 3'd7 || byte_idx != last_idx)
                    begin
                        state   <= S_LOW;
                        sio_clk <= 1'b0;
                        bit_idx <= bit_idx + 1'b1;      // Wraps into the next byte
                        if (bit_idx == 3'd7)
                        begin
                            byte_idx <= byte_idx + 1'b1;
                            oe       <= (grp != 2'd3);  // Release dio for key bytes
                        end
                    end
                    else                                // End of group
                    begin
                        state <= S_GAP;
                        stb   <= 1'b1;
                        oe    <= 1'b0;
                        grp   <= grp + 1'b1;
                        if (grp == 2'd3)
                            disp.keys <= key_merge;     // Frame done
                    end
                end

                default: state <= S_GAP;
            endcase
        end
    end

endmodule

//--- include/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Onboard resources
`define W_KEY        2      // Push buttons, active low
`define W_SW         3      // Slide switches
`define W_LED        8      // Green LEDs

// TM1638 daughterboard
`define TM_DIGITS    8      // Digits, LEDs and keys on the board
`define TM_HALF_DIV  4      // Clk cycles per serial clock half period

// Audio and display timing
`define I2S_HALF_DIV 4      // Clk cycles per bit clock half period
`define SCAN_DIV     16     // Clk cycles on each digit of the scan

`endif

//--- list.f
+incdir+include
hw/board_pkg.sv
hw/audio_pkg.sv
hw/display_if.sv
hw/lab_top.sv
hw/tm1638_ctrl.sv
hw/i2s_mic_rx.sv
hw/i2s_dac_tx.sv
hw/board_top.sv
sim/board_sva.sv
sim/tb_board_top.sv

//--- sim/board_sva.sv
module board_sva
#(
    parameter bit tm_link = 1'b0        // Watch the TM1638 pins, else the DAC pins
)
(
    input logic clk,
    input logic rst,
    input logic stb,
    input logic sio_clk,
    input logic bclk,
    input logic lrclk,
    input logic sdata
);

    timeunit 1ns;
    timeprecision 100ps;

    generate
        if (tm_link)
        begin : g_tm
            // ----------------------------------------------------------
            // TM1638 link

            serial_idle: assert property (@(posedge clk) disable iff (rst) stb |-> sio_clk)
                else $error("serial clock low outside a group");
        end
        else
        begin : g_dac
            // ----------------------------------------------------------
            // I2S DAC pins

            data_stable: assert property (@(posedge clk) disable iff (rst)
                $changed(sdata) |-> !bclk)
                else $error("sdata moved while bclk high");

            lr_on_fall: assert property (@(posedge clk) disable iff (rst)
                $changed(lrclk) |-> $fell(bclk))
                else $error("lrclk moved away from a falling bclk");
        end
    endgenerate

endmodule

// Each instance watches the pins of the block it sits in
bind tm1638_ctrl board_sva #(.tm_link(1'b1)) tm_sva
(
    .clk     ( clk     ),
    .rst     ( rst     ),
    .stb     ( stb     ),
    .sio_clk ( sio_clk ),
    .bclk    (         ),
    .lrclk   (         ),
    .sdata   (         )
);

bind i2s_dac_tx board_sva #(.tm_link(1'b0)) dac_sva
(
    .clk     ( clk   ),
    .rst     ( rst   ),
    .stb     (       ),
    .sio_clk (       ),
    .bclk    ( bclk  ),
    .lrclk   ( lrclk ),
    .sdata   ( sdata )
);

//--- sim/tb_board_top.sv
`include "board_cfg.svh"

module tb_board_top;

    timeunit 1ns;
    timeprecision 100ps;

    import board_pkg::*;
    import audio_pkg::*;

    // Clk cycles per refresh frame and per I2S frame
    localparam int frame_bytes = 1 + (1 + tm_write_bytes) + 1 + (1 + tm_read_bytes);
    localparam int frame_clk   = (frame_bytes * 16 + 4 * 2) * `TM_HALF_DIV;
    localparam int i2s_clk     = 2 * i2s_slot_bits * 2 * `I2S_HALF_DIV;
    localparam int run_frames  = 10;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    logic [`W_KEY - 1:0] key;
    logic [`W_SW  - 1:0] sw;
    logic                mic_sd;
    logic [`W_LED - 1:0] led;
    logic                tm_stb, tm_clk, mic_lr, mic_ws, mic_sck;
    logic                i2s_mclk, i2s_bclk, i2s_lrclk, i2s_sdata;
    wire                 tm_dio;

    int          seed = 32'haea5;
    logic        drv_en = 1'b0;             // TM1638 model owns dio
    logic        drv_bit;
    logic        grp_open = 1'b0;
    int          nbit = 0;
    int          nbyte = 0;
    int          gi = 0;                    // Expected group in the frame
    int          frames = 0;
    logic [7:0]  cur;
    logic [7:0]  bytes [17];
    logic [7:0]  rd_bytes [4];              // Key bytes for the next read
    logic [`W_KEY - 1:0] pend_key;
    logic [`W_SW  - 1:0] pend_sw;
    key_t        exp_mask = '0;
    key_t        new_mask;
    led_t        led_bytes;
    seg_t        exp_seg;
    logic        stable = 1'b0;
    int          digit_checks = 0;
    int          mcnt = 0;
    mic_t        mic_cur;
    mic_t        mic_latched = '0;
    sound_t      snd_cur = '0;
    sound_t      snd_prev = '0;
    int          dcnt = 0;
    sound_t      dac_exp = '0;
    sound_t      dac_word;
    int          dac_on = 0;
    int          dac_off = 0;

    assign tm_dio = drv_en ? drv_bit : 1'bz;
    pullup (tm_dio);

    board_top uut
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .led       ( led       ),
        .tm_stb    ( tm_stb    ),
        .tm_clk    ( tm_clk    ),
        .tm_dio    ( tm_dio    ),
        .mic_lr    ( mic_lr    ),
        .mic_ws    ( mic_ws    ),
        .mic_sck   ( mic_sck   ),
        .i2s_mclk  ( i2s_mclk  ),
        .i2s_bclk  ( i2s_bclk  ),
        .i2s_lrclk ( i2s_lrclk ),
        .i2s_sdata ( i2s_sdata )
    );

    initial
    begin
        forever #2 clk = ~ clk;             // 4 ns period
    end

    // ----------------------------------------------------------
    // Failure reporting and compare tasks

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        if (got !== exp)
            stop_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        if (got !== exp)
            stop_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_key(input string name, input key_t got, input key_t exp);
        if (got !== exp)
            stop_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_sound(input string name, input sound_t got, input sound_t exp);
        if (got !== exp)
            stop_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Seven-segment code, abcdefgh with a in bit 7
    function automatic seg_t seg_code(input logic [3:0] v);
        seg_t table_v [16];
        table_v = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
                    8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E};
        return table_v [v];
    endfunction

    // ----------------------------------------------------------
    // TM1638 model

    always @(negedge tm_stb)
        grp_open = 1'b1;

    always @(posedge tm_clk)
    begin
        if (grp_open)
        begin
            cur [nbit] = tm_dio;            // LSB first
            nbit++;
            if (nbit == 8)
            begin
                if (nbyte < 17)
                    bytes [nbyte] = cur;
                nbyte++;
                nbit = 0;
            end
        end
    end

    // Key bytes go out while the serial clock is low
    always @(negedge tm_clk)
    begin
        if (grp_open && nbyte >= 1 && nbyte <= 4 && bytes [0] == tm_cmd_read)
        begin
            cur [0] = rd_bytes [nbyte - 1][nbit];
            #1 drv_en = 1'b1;
            drv_bit = cur [0];
        end
    end

    always @(posedge tm_stb)
    begin
        if (grp_open)
        begin
            grp_open = 1'b0;
            drv_en   = 1'b0;
            case (gi)
                0:
                    if (nbyte != 1 || bytes [0] != tm_cmd_write)
                        stop_fail("Frame does not open with the write command");
                1:
                begin
                    if (nbyte != 1 + tm_write_bytes || bytes [0] != tm_cmd_addr)
                        stop_fail("Address group has a wrong command or length");
                    for (int i = 0; i < `TM_DIGITS; i++)
                        led_bytes [i] = bytes [2 + 2 * i][0];
                    check_led("led bytes", led_bytes, led_t'(exp_mask));
                    check_led("led", led, led_t'(exp_mask));
                    check_key("lab_keys", uut.lab_keys, exp_mask);
                    if (frames >= 2 && stable)
                    begin
                        for (int i = 0; i < `TM_DIGITS; i++)
                        begin
                            case (i)
                                0:       exp_seg = seg_code(exp_mask [3:0]);
                                1:       exp_seg = seg_code(exp_mask [7:4]);
                                2:       exp_seg = seg_code(4'(sw));
                                default: exp_seg = '0;      // Blank digit
                            endcase
                            check_seg($sformatf("digit %0d", i), bytes [1 + 2 * i], exp_seg);
                        end
                        digit_checks++;
                    end
                end
                2:
                    if (nbyte != 1 || bytes [0] != tm_cmd_on)
                        stop_fail("Display-on group is out of order");
                default:
                begin
                    if (nbyte != 1 + tm_read_bytes || bytes [0] != tm_cmd_read)
                        stop_fail("Read group is out of order");
                    for (int b = 0; b < 4; b++)
                    begin
                        new_mask [b]     = rd_bytes [b][0];     // Key b
                        new_mask [b + 4] = rd_bytes [b][4];     // Key b + 4
                    end
                    new_mask [`W_KEY - 1:0] |= ~ pend_key;
                    stable   = (new_mask == exp_mask) && (pend_sw == sw);
                    exp_mask = new_mask;
                    frames++;
                    #1 key = pend_key;
                    sw = pend_sw;
                    if (frames % 2 == 0)                        // New stimulus every other frame
                    begin
                        for (int b = 0; b < 4; b++)
                            rd_bytes [b] = $random(seed);
                        pend_key = $random(seed);
                        pend_sw  = $random(seed);
                    end
                end
            endcase
            gi    = (gi + 1) % 4;
            nbyte = 0;
            nbit  = 0;
        end
    end

    // ----------------------------------------------------------
    // Microphone and DAC models

    always @(negedge mic_sck)
    begin
        if (!rst)
        begin
            mcnt = (mcnt + 1) % 64;
            if (mcnt == 1)
                mic_cur = $random(seed);
            if (mcnt == 32)
                mic_latched = mic_cur;          // Frame boundary, ws rises
            if (mcnt >= 1 && mcnt <= 24)
                #1 mic_sd = mic_cur [24 - mcnt];    // MSB first
            else
                #1 mic_sd = 1'b0;
        end
    end

    // Sound register of the lab logic, one stage
    always @(posedge clk)
    begin
        snd_prev = snd_cur;
        snd_cur  = rst ? '0 : (sw [0] ? mic_latched [23:8] : '0);
    end

    always @(negedge i2s_bclk)
    begin
        if (!rst)
        begin
            dcnt = (dcnt + 1) % 64;
            if (dcnt == 0)
                dac_exp = snd_prev;             // Sample taken at lrclk fall
        end
    end

    always @(posedge i2s_bclk)
    begin
        if ((dcnt >= 1 && dcnt <= 16) || (dcnt >= 33 && dcnt <= 48))
            dac_word = {dac_word [14:0], i2s_sdata};
        if (dcnt == 16 || dcnt == 48)
        begin
            check_sound(dcnt == 16 ? "i2s_sdata left" : "i2s_sdata right", dac_word, dac_exp);
            if (dac_exp != '0)
                dac_on++;
            else
                dac_off++;
        end
    end

    // ----------------------------------------------------------
    // Reset, run length and watchdog

    initial
    begin
        key      = 2'b11;                   // Released
        sw       = '0;
        mic_sd   = 1'b0;
        pend_key = $random(seed);
        pend_sw  = $random(seed);
        for (int b = 0; b < 4; b++)
            rd_bytes [b] = $random(seed);
        repeat (4) @(posedge clk);
        if (tm_stb !== 1'b1 || tm_clk !== 1'b1 || tm_dio !== 1'b1)
            stop_fail("Serial link is not idle in reset");
        if ({mic_lr, mic_ws, mic_sck, i2s_mclk, i2s_bclk, i2s_lrclk, i2s_sdata} !== '0)
            stop_fail("I2S pins are not low in reset");
        check_led("led", led, '0);
        #1 rst = 1'b0;

        wait (frames >= run_frames);
        @(posedge clk);
        if (digit_checks == 0 || dac_on == 0 || dac_off == 0)
            stop_fail("Too few digit or audio frames were checked");
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial
    begin
        #((12 * frame_clk + 12 * i2s_clk) * 4);
        stop_fail("Watchdog expired before the test finished");
    end

endmodule
